// ==== mem_pkg.sv ====
package mem_pkg;

	// Word request from the CPU side
	typedef struct packed {
		logic [31:0] addr;
		logic        we;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} cpu_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} cpu_rsp_t;

	// Request to the backing memory, addr is line aligned
	typedef struct packed {
		logic [31:0] addr;
		logic        we;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [1:0]  off; // Word within the line, used by writes
	} line_req_t;

	typedef logic [3:0][31:0] line_t;

	typedef enum logic [2:0] {IDLE, LOOKUP, FILL, WRITE, DONE} cache_state_e;

endpackage

// ==== perf_pkg.sv ====
package perf_pkg;

	localparam int CNT_W = 16;

	// Four counters, two bytes each
	localparam int REPORT_BYTES = 8;

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		STOP,
		DONE
	} tx_state_e;

endpackage

// ==== mem_router.sv ====
`timescale 1ns/1ps

module mem_router #(
	parameter logic [31:0] END_INST = 32'h0000_03FC
) (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::cpu_req_t cpu_req_i,
	input  logic              cpu_valid_i,
	output mem_pkg::cpu_rsp_t cpu_o,
	output logic              cpu_ack_o,
	output logic              i_req_o,
	output logic              d_req_o,
	output mem_pkg::cpu_req_t fwd_o,
	input  mem_pkg::cpu_rsp_t i_rsp_i,
	input  mem_pkg::cpu_rsp_t d_rsp_i,
	input  logic              i_ack_i,
	input  logic              d_ack_i
);

	logic held;
	logic ack_seen;
	logic route_q; // 1 selects the data cache
	logic route_now;
	logic own_ack;
	logic live;
	logic to_d;

	assign route_now = cpu_req_i.we | (cpu_req_i.addr > END_INST);
	assign own_ack = route_q ? d_ack_i : i_ack_i;
	// The held route is released as soon as the owner's ack has fallen
	assign live = held & ~(ack_seen & ~own_ack);
	assign to_d = live ? route_q : route_now;

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
			ack_seen <= 1'b0;
			route_q <= 1'b0;
		end else if (!live) begin
			held <= cpu_valid_i;
			ack_seen <= 1'b0;
			if (cpu_valid_i)
				route_q <= route_now;
		end else if (own_ack) begin
			ack_seen <= 1'b1;
		end
	end

	assign fwd_o = cpu_req_i; // Both caches see the request, only the owner gets req
	assign i_req_o = cpu_valid_i & ~to_d;
	assign d_req_o = cpu_valid_i & to_d;
	assign cpu_o = to_d ? d_rsp_i : i_rsp_i;
	assign cpu_ack_o = to_d ? d_ack_i : i_ack_i;

endmodule

// ==== l1_cache.sv ====
`timescale 1ns/1ps

module l1_cache #(
	parameter int LINES = 16
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_i,
	output logic               ack_o,
	input  mem_pkg::cpu_req_t  cpu_i,
	output mem_pkg::cpu_rsp_t  rsp_o,
	output logic               mem_req_o,
	output mem_pkg::line_req_t mem_o,
	input  logic               mem_ack_i,
	input  mem_pkg::line_t     mem_line_i,
	output logic               read_ev_o,
	output logic               miss_ev_o
);

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = 28 - IDX_W;

	mem_pkg::cache_state_e state;
	mem_pkg::cpu_req_t     req_q;

	logic [TAG_W-1:0] tags [LINES];
	mem_pkg::line_t   lines [LINES];
	logic [LINES-1:0] valid;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [1:0]       off;
	logic             hit;

	// Index sits right above the word offset
	assign idx = req_q.addr[4 +: IDX_W];
	assign tag = req_q.addr[31 -: TAG_W];
	assign off = req_q.addr[3:2];
	assign hit = valid[idx] && (tags[idx] == tag);

	assign mem_o = '{
		addr:  {req_q.addr[31:4], 4'b0000},
		we:    req_q.we,
		wdata: req_q.wdata,
		strb:  req_q.strb,
		off:   off
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::IDLE;
			ack_o <= 1'b0;
			mem_req_o <= 1'b0;
			read_ev_o <= 1'b0;
			miss_ev_o <= 1'b0;
			valid <= '0;
		end else begin
			read_ev_o <= 1'b0;
			miss_ev_o <= 1'b0;
			case (state)
				mem_pkg::IDLE: begin
					if (req_i) begin
						state <= mem_pkg::LOOKUP;
						read_ev_o <= ~cpu_i.we;
					end
				end
				mem_pkg::LOOKUP: begin
					if (req_q.we) begin // Write-through, hit or not
						mem_req_o <= 1'b1;
						state <= mem_pkg::WRITE;
					end else if (hit) begin
						ack_o <= 1'b1;
						state <= mem_pkg::DONE;
					end else begin
						miss_ev_o <= 1'b1;
						mem_req_o <= 1'b1;
						state <= mem_pkg::FILL;
					end
				end
				mem_pkg::FILL: begin
					if (mem_ack_i) begin
						mem_req_o <= 1'b0;
						valid[idx] <= 1'b1;
						ack_o <= 1'b1;
						state <= mem_pkg::DONE;
					end
				end
				mem_pkg::WRITE: begin
					if (mem_ack_i) begin
						mem_req_o <= 1'b0;
						ack_o <= 1'b1;
						state <= mem_pkg::DONE;
					end
				end
				mem_pkg::DONE: begin
					if (!req_i) begin
						ack_o <= 1'b0;
						state <= mem_pkg::IDLE;
					end
				end
				default: state <= mem_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mem_pkg::IDLE && req_i)
			req_q <= cpu_i;
		if (state == mem_pkg::LOOKUP && hit) begin
			if (req_q.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req_q.strb[b])
						lines[idx][off][8*b +: 8] <= req_q.wdata[8*b +: 8];
				end
			end else begin
				rsp_o.rdata <= lines[idx][off];
			end
		end
		if (state == mem_pkg::FILL && mem_ack_i) begin
			lines[idx] <= mem_line_i;
			tags[idx] <= tag;
			rsp_o.rdata <= mem_line_i[off]; // Critical word straight from the fill
		end
	end

endmodule

// ==== backing_mem.sv ====
`timescale 1ns/1ps

module backing_mem #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS = 1024
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_req_i,
	input  logic               d_req_i,
	input  mem_pkg::line_req_t i_i,
	input  mem_pkg::line_req_t d_i,
	output logic               i_ack_o,
	output logic               d_ack_o,
	output mem_pkg::line_t     line_o
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int CW = $clog2(MEM_LATENCY + 1);

	logic [31:0] mem [MEM_WORDS];

	logic               busy;
	logic               ack_q;
	logic               gnt_d; // Port that holds the grant, 1 is data
	logic [CW-1:0]      cnt;
	mem_pkg::line_req_t sel;
	logic               sel_req;
	logic [AW-3:0]      row;

	assign sel = gnt_d ? d_i : i_i;
	assign sel_req = gnt_d ? d_req_i : i_req_i;
	assign row = sel.addr[AW+1:4];

	assign i_ack_o = ack_q & ~gnt_d;
	assign d_ack_o = ack_q & gnt_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			ack_q <= 1'b0;
			gnt_d <= 1'b0;
			cnt <= '0;
		end else if (!busy && !ack_q) begin
			if (i_req_i || d_req_i) begin
				busy <= 1'b1;
				gnt_d <= ~i_req_i; // Instruction port has priority
				cnt <= CW'(MEM_LATENCY - 1);
			end
		end else if (busy) begin
			if (cnt == '0) begin
				busy <= 1'b0;
				ack_q <= 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end else if (!sel_req) begin
			ack_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (busy && cnt == '0) begin
			if (sel.we) begin
				for (int b = 0; b < 4; b++) begin
					if (sel.strb[b])
						mem[{row, sel.off}][8*b +: 8] <= sel.wdata[8*b +: 8];
				end
			end else begin
				for (int w = 0; w < 4; w++)
					line_o[w] <= mem[{row, 2'(w)}];
			end
		end
	end

endmodule

// ==== perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_read_i,
	input  logic       i_miss_i,
	input  logic       d_read_i,
	input  logic       d_miss_i,
	input  logic       report_req_i,
	output logic       report_ack_o,
	output logic       tx_req_o,
	output logic [7:0] tx_byte_o,
	input  logic       tx_ack_i
);

	localparam int RW = perf_pkg::REPORT_BYTES * 8;
	localparam int BW = $clog2(perf_pkg::REPORT_BYTES);

	logic [perf_pkg::CNT_W-1:0] i_reads, i_misses, d_reads, d_misses;
	logic [RW-1:0]              snap;
	logic [BW-1:0]              byte_cnt;
	logic                       sending;

	assign tx_byte_o = snap[RW-1 -: 8];

	always_ff @(posedge clk) begin
		if (rst) begin
			i_reads <= '0;
			i_misses <= '0;
			d_reads <= '0;
			d_misses <= '0;
			sending <= 1'b0;
			byte_cnt <= '0;
			tx_req_o <= 1'b0;
			report_ack_o <= 1'b0;
		end else begin
			// Counters stick at all ones
			if (i_read_i && i_reads != '1) i_reads <= i_reads + 1'b1;
			if (i_miss_i && i_misses != '1) i_misses <= i_misses + 1'b1;
			if (d_read_i && d_reads != '1) d_reads <= d_reads + 1'b1;
			if (d_miss_i && d_misses != '1) d_misses <= d_misses + 1'b1;

			if (!sending && !report_ack_o && report_req_i) begin
				sending <= 1'b1;
				snap <= {i_reads, i_misses, d_reads, d_misses}; // Consistent snapshot
				byte_cnt <= '0;
				tx_req_o <= 1'b1;
			end else if (sending) begin
				if (tx_req_o && tx_ack_i) begin
					tx_req_o <= 1'b0;
				end else if (!tx_req_o && !tx_ack_i) begin
					if (byte_cnt == BW'(perf_pkg::REPORT_BYTES - 1)) begin
						sending <= 1'b0;
						report_ack_o <= 1'b1;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						snap <= snap << 8;
						tx_req_o <= 1'b1;
					end
				end
			end else if (report_ack_o && !report_req_i) begin
				report_ack_o <= 1'b0;
			end
		end
	end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       req_i,
	input  logic [7:0] byte_i,
	output logic       ack_o,
	output logic       tx_o
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	perf_pkg::tx_state_e state;
	logic [CW-1:0]       clk_cnt;
	logic [2:0]          bit_idx;
	logic [7:0]          shreg;
	logic                bit_end;

	assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= perf_pkg::IDLE;
			tx_o <= 1'b1; // Line idles high
			ack_o <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				perf_pkg::IDLE: begin
					clk_cnt <= '0;
					if (req_i) begin
						shreg <= byte_i;
						tx_o <= 1'b0;
						state <= perf_pkg::START;
					end
				end
				perf_pkg::START: begin
					if (bit_end) begin
						tx_o <= shreg[0];
						bit_idx <= '0;
						state <= perf_pkg::DATA;
					end
				end
				perf_pkg::DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							tx_o <= 1'b1;
							state <= perf_pkg::STOP;
						end else begin
							tx_o <= shreg[1]; // LSB first
							shreg <= shreg >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				perf_pkg::STOP: begin
					if (bit_end) begin
						ack_o <= 1'b1;
						state <= perf_pkg::DONE;
					end
				end
				perf_pkg::DONE: begin
					clk_cnt <= '0;
					if (!req_i) begin
						ack_o <= 1'b0;
						state <= perf_pkg::IDLE;
					end
				end
				default: state <= perf_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== mem_sys_top.sv ====
`timescale 1ns/1ps

module mem_sys_top #(
	parameter logic [31:0] END_INST = 32'h0000_03FC,
	parameter int LINES = 16,
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS = 1024,
	parameter int CLKS_PER_BIT = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::cpu_req_t cpu_req_i,
	input  logic              cpu_valid_i,
	output mem_pkg::cpu_rsp_t cpu_o,
	output logic              cpu_ack_o,
	input  logic              report_req_i,
	output logic              report_ack_o,
	output logic              tx_o
);

	mem_pkg::cpu_req_t  fwd;
	mem_pkg::cpu_rsp_t  i_rsp, d_rsp;
	mem_pkg::line_req_t i_mem, d_mem;
	mem_pkg::line_t     line;
	logic               i_req, d_req, i_ack, d_ack;
	logic               i_mem_req, d_mem_req, i_mem_ack, d_mem_ack;
	logic               i_read, i_miss, d_read, d_miss;
	logic               tx_req, tx_ack;
	logic [7:0]         tx_byte;

	mem_router #(.END_INST(END_INST)) u_router (
		.clk(clk), .rst(rst),
		.cpu_req_i(cpu_req_i), .cpu_valid_i(cpu_valid_i),
		.cpu_o(cpu_o), .cpu_ack_o(cpu_ack_o),
		.i_req_o(i_req), .d_req_o(d_req), .fwd_o(fwd),
		.i_rsp_i(i_rsp), .d_rsp_i(d_rsp), .i_ack_i(i_ack), .d_ack_i(d_ack)
	);

	l1_cache #(.LINES(LINES)) u_l1i (
		.clk(clk), .rst(rst), .req_i(i_req), .ack_o(i_ack), .cpu_i(fwd), .rsp_o(i_rsp),
		.mem_req_o(i_mem_req), .mem_o(i_mem), .mem_ack_i(i_mem_ack), .mem_line_i(line),
		.read_ev_o(i_read), .miss_ev_o(i_miss)
	);

	l1_cache #(.LINES(LINES)) u_l1d (
		.clk(clk), .rst(rst), .req_i(d_req), .ack_o(d_ack), .cpu_i(fwd), .rsp_o(d_rsp),
		.mem_req_o(d_mem_req), .mem_o(d_mem), .mem_ack_i(d_mem_ack), .mem_line_i(line),
		.read_ev_o(d_read), .miss_ev_o(d_miss)
	);

	backing_mem #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) u_mem (
		.clk(clk), .rst(rst), .i_req_i(i_mem_req), .d_req_i(d_mem_req),
		.i_i(i_mem), .d_i(d_mem), .i_ack_o(i_mem_ack), .d_ack_o(d_mem_ack), .line_o(line)
	);

	perf_counters u_perf (
		.clk(clk), .rst(rst),
		.i_read_i(i_read), .i_miss_i(i_miss), .d_read_i(d_read), .d_miss_i(d_miss),
		.report_req_i(report_req_i), .report_ack_o(report_ack_o),
		.tx_req_o(tx_req), .tx_byte_o(tx_byte), .tx_ack_i(tx_ack)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
		.clk(clk), .rst(rst), .req_i(tx_req), .byte_i(tx_byte), .ack_o(tx_ack), .tx_o(tx_o)
	);

endmodule

// ==== tb_mem_sys.sv ====
`timescale 1ns/1ps

module tb_mem_sys;

	localparam logic [31:0] END_INST = 32'h0000_03FC;
	localparam int LINES = 16;
	localparam int IDX_W = $clog2(LINES);
	localparam int CLKS_PER_BIT = 4;
	localparam int ACK_LIMIT = 64;
	localparam int START_LIMIT = 100;
	localparam int REPORT_LIMIT = 1000;
	localparam int NB = perf_pkg::REPORT_BYTES;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_REP} op_kind_e;

	typedef struct packed {
		op_kind_e    kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] exp; // Expected word for reads
	} op_t;

	localparam int NUM_OPS = 35;

	// Index is addr[7:4], so 0x000, 0x100 and 0x400, 0x800 collide
	localparam op_t OPS [NUM_OPS] = '{
		'{OP_WR,  32'h0000_0000, 32'h0000_0013, 4'hF, 32'h0},
		'{OP_WR,  32'h0000_0004, 32'h0010_0093, 4'hF, 32'h0},
		'{OP_WR,  32'h0000_0400, 32'hCAFE_F00D, 4'hF, 32'h0},
		'{OP_WR,  32'h0000_0404, 32'h1234_5678, 4'hF, 32'h0},
		'{OP_RD,  32'h0000_0000, 32'h0, 4'h0, 32'h0000_0013},
		'{OP_RD,  32'h0000_0004, 32'h0, 4'h0, 32'h0010_0093},
		'{OP_RD,  32'h0000_0400, 32'h0, 4'h0, 32'hCAFE_F00D},
		'{OP_RD,  32'h0000_0404, 32'h0, 4'h0, 32'h1234_5678},
		'{OP_WR,  32'h0000_0404, 32'hAAAA_AAAA, 4'b0001, 32'h0},
		'{OP_RD,  32'h0000_0404, 32'h0, 4'h0, 32'h1234_56AA},
		'{OP_WR,  32'h0000_0404, 32'hBBBB_BBBB, 4'b0011, 32'h0},
		'{OP_RD,  32'h0000_0404, 32'h0, 4'h0, 32'h1234_BBBB},
		'{OP_WR,  32'h0000_0404, 32'hCCCC_CCCC, 4'b1100, 32'h0},
		'{OP_RD,  32'h0000_0404, 32'h0, 4'h0, 32'hCCCC_BBBB},
		// Uncached partial writes, one strobe per line so each one shows
		'{OP_WR,  32'h0000_0800, 32'h1122_3344, 4'hF, 32'h0},
		'{OP_WR,  32'h0000_0800, 32'h0000_00EE, 4'b0001, 32'h0},
		'{OP_WR,  32'h0000_0810, 32'h5566_7788, 4'hF, 32'h0},
		'{OP_WR,  32'h0000_0810, 32'h0000_DD00, 4'b0011, 32'h0},
		'{OP_WR,  32'h0000_0820, 32'h4433_2211, 4'hF, 32'h0},
		'{OP_WR,  32'h0000_0820, 32'h9988_0000, 4'b1100, 32'h0},
		'{OP_RD,  32'h0000_0800, 32'h0, 4'h0, 32'h1122_33EE},
		'{OP_RD,  32'h0000_0810, 32'h0, 4'h0, 32'h5566_DD00},
		'{OP_RD,  32'h0000_0820, 32'h0, 4'h0, 32'h9988_2211},
		'{OP_RD,  32'h0000_0400, 32'h0, 4'h0, 32'hCAFE_F00D},
		'{OP_RD,  32'h0000_0404, 32'h0, 4'h0, 32'hCCCC_BBBB},
		'{OP_WR,  32'h0000_0100, 32'h0000_006F, 4'hF, 32'h0},
		'{OP_RD,  32'h0000_0100, 32'h0, 4'h0, 32'h0000_006F},
		'{OP_RD,  32'h0000_0000, 32'h0, 4'h0, 32'h0000_0013},
		'{OP_RD,  32'h0000_0004, 32'h0, 4'h0, 32'h0010_0093},
		'{OP_WR,  32'h0000_03FC, 32'hDEAD_BEEF, 4'hF, 32'h0},
		'{OP_RD,  32'h0000_03FC, 32'h0, 4'h0, 32'hDEAD_BEEF},
		'{OP_REP, 32'h0, 32'h0, 4'h0, 32'h0},
		'{OP_RD,  32'h0000_03FC, 32'h0, 4'h0, 32'hDEAD_BEEF},
		'{OP_RD,  32'h0000_0800, 32'h0, 4'h0, 32'h1122_33EE},
		'{OP_REP, 32'h0, 32'h0, 4'h0, 32'h0}
	};

	logic              clk = 1'b0;
	logic              rst;
	mem_pkg::cpu_req_t cpu_req_i;
	logic              cpu_valid_i;
	mem_pkg::cpu_rsp_t cpu_o;
	logic              cpu_ack_o;
	logic              report_req_i;
	logic              report_ack_o;
	logic              tx_o;

	int errors = 0;
	int timeouts = 0;

	// Reference model: line address per cache slot and the four counters
	logic [27:0]                m_line [2][LINES];
	logic                       m_valid [2][LINES];
	logic [perf_pkg::CNT_W-1:0] exp_cnt [4];
	logic [7:0]                 rx_q [$];

	mem_sys_top #(
		.END_INST(END_INST),
		.LINES(LINES),
		.MEM_LATENCY(4),
		.MEM_WORDS(1024),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) dut_i (
		.clk(clk), .rst(rst),
		.cpu_req_i(cpu_req_i), .cpu_valid_i(cpu_valid_i),
		.cpu_o(cpu_o), .cpu_ack_o(cpu_ack_o),
		.report_req_i(report_req_i), .report_ack_o(report_ack_o),
		.tx_o(tx_o)
	);

	always #50 clk = ~clk;

	function automatic logic [perf_pkg::CNT_W-1:0] sat_inc(input logic [perf_pkg::CNT_W-1:0] v);
		return (v == '1) ? v : v + 1'b1;
	endfunction

	task automatic model_clear;
		for (int c = 0; c < 2; c++) begin
			for (int l = 0; l < LINES; l++) begin
				m_valid[c][l] = 1'b0;
				m_line[c][l] = '0;
			end
		end
		for (int k = 0; k < 4; k++)
			exp_cnt[k] = '0;
	endtask

	// Reads above the bound land in the data cache, slot 1
	task automatic model_read(input logic [31:0] addr);
		int c;
		logic [IDX_W-1:0] idx;
		c = (addr > END_INST) ? 1 : 0;
		idx = addr[4 +: IDX_W];
		exp_cnt[2*c] = sat_inc(exp_cnt[2*c]);
		if (!m_valid[c][idx] || m_line[c][idx] != addr[31:4]) begin
			exp_cnt[2*c+1] = sat_inc(exp_cnt[2*c+1]);
			m_valid[c][idx] = 1'b1;
			m_line[c][idx] = addr[31:4];
		end
	endtask

	task automatic apply_cpu(input op_t op);
		int n;
		cpu_req_i.addr = op.addr;
		cpu_req_i.we = (op.kind == OP_WR);
		cpu_req_i.wdata = op.data;
		cpu_req_i.strb = op.strb;
		cpu_valid_i = 1'b1;
		if (op.kind == OP_RD)
			model_read(op.addr);
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!cpu_ack_o && n < ACK_LIMIT);
		if (!cpu_ack_o) begin
			$display("No cpu_ack_o for the %s at %08h within %0d cycles",
				(op.kind == OP_RD) ? "read" : "write", op.addr, ACK_LIMIT);
			timeouts++;
		end else if (op.kind == OP_RD) begin
			assert (cpu_o.rdata === op.exp) else begin
				$display("ERR cpu_o.rdata at %08h: got %08h expected %08h",
					op.addr, cpu_o.rdata, op.exp);
				errors++;
			end
		end
		cpu_valid_i = 1'b0;
		if (cpu_ack_o) begin
			n = 0;
			do begin
				@(posedge clk);
				#1;
				n++;
			end while (cpu_ack_o && n < ACK_LIMIT);
			if (cpu_ack_o) begin
				$display("cpu_ack_o stayed high after the request was dropped at %08h", op.addr);
				timeouts++;
			end
		end
	endtask

	// Samples tx_o at falling edges, near the middle of each bit
	task automatic receive_byte(output logic [7:0] b, output logic ok);
		int n;
		logic [7:0] sh;
		n = 0;
		sh = '0;
		b = '0;
		ok = 1'b0;
		do begin
			@(negedge clk);
			n++;
		end while (tx_o !== 1'b0 && n < START_LIMIT);
		if (tx_o !== 1'b0) begin
			$display("No start bit on tx_o within %0d cycles", START_LIMIT);
			timeouts++;
		end else begin
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			assert (tx_o === 1'b0) else begin
				$display("ERR tx_o start bit: got %h expected 0", tx_o);
				errors++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				sh = {tx_o, sh[7:1]}; // LSB arrives first
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (tx_o === 1'b1) else begin
				$display("ERR tx_o stop bit: got %h expected 1", tx_o);
				errors++;
			end
			b = sh;
			ok = 1'b1;
		end
	endtask

	task automatic run_report;
		logic [7:0] exp_bytes [NB];
		logic [7:0] b;
		logic       rx_ok;
		int         n;
		for (int k = 0; k < 4; k++) begin
			exp_bytes[2*k] = exp_cnt[k][15:8];
			exp_bytes[2*k+1] = exp_cnt[k][7:0];
		end
		rx_q.delete();
		rx_ok = 1'b1;
		fork
			begin
				report_req_i = 1'b1;
				n = 0;
				do begin
					@(posedge clk);
					#1;
					n++;
				end while (!report_ack_o && n < REPORT_LIMIT);
				if (!report_ack_o) begin
					$display("No report_ack_o within %0d cycles", REPORT_LIMIT);
					timeouts++;
				end else begin
					assert (rx_q.size() == NB) else begin
						$display("report_ack_o rose after only %0d report bytes", rx_q.size());
						errors++;
					end
				end
				report_req_i = 1'b0;
				n = 0;
				while (report_ack_o && n < ACK_LIMIT) begin
					@(posedge clk);
					#1;
					n++;
				end
				if (report_ack_o) begin
					$display("report_ack_o stayed high after the report request was dropped");
					timeouts++;
				end
			end
			begin
				for (int i = 0; i < NB && rx_ok; i++) begin
					receive_byte(b, rx_ok);
					if (rx_ok)
						rx_q.push_back(b);
				end
			end
		join
		assert (rx_q.size() == NB) else begin
			$display("Report delivered %0d bytes instead of %0d", rx_q.size(), NB);
			errors++;
		end
		for (int i = 0; i < rx_q.size() && i < NB; i++) begin
			assert (rx_q[i] === exp_bytes[i]) else begin
				$display("ERR tx_o byte %0d: got %02h expected %02h", i, rx_q[i], exp_bytes[i]);
				errors++;
			end
		end
	endtask

	initial begin
		int i;
		rst = 1'b1;
		cpu_req_i = '0;
		cpu_valid_i = 1'b0;
		report_req_i = 1'b0;
		model_clear();
		repeat (2) @(posedge clk);
		#1;
		assert (cpu_ack_o === 1'b0 && report_ack_o === 1'b0 && tx_o === 1'b1) else begin
			$display("ERR reset outputs: cpu_ack_o %h report_ack_o %h tx_o %h expected 0 0 1",
				cpu_ack_o, report_ack_o, tx_o);
			errors++;
		end
		rst = 1'b0;
		i = 0;
		while (i < NUM_OPS && timeouts == 0) begin
			if (OPS[i].kind == OP_REP)
				run_report();
			else
				apply_cpu(OPS[i]);
			i++;
		end
		$display("Failed checks: %0d, timeouts: %0d, operations applied: %0d of %0d",
			errors, timeouts, i, NUM_OPS);
		if (errors == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
mem_pkg.sv
perf_pkg.sv
mem_router.sv
l1_cache.sv
backing_mem.sv
perf_counters.sv
uart_tx.sv
mem_sys_top.sv
tb_mem_sys.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_mem_sys -f project.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
